// File: box_table/box_host_port.sv
module box_host_port #(
    parameter int N_BOX = 4
) (
    input  logic                                    clk,
    input  logic                                    i_reset,
    input  logic                                    i_cfg_we,
    input  logic [overlay_pkg::box_w(N_BOX)-1:0]    i_cfg_box,
    input  overlay_pkg::field_t                     i_cfg_field,
    input  overlay_pkg::box_data_t                  i_cfg_data,
    output logic                                    o_cfg_busy,
    box_bus_if.requester                            bus
);
    import overlay_pkg::*;

    localparam int ADDR_W = box_w(N_BOX) + $bits(field_t);

    logic              pending;
    logic [ADDR_W-1:0] pend_addr;
    box_data_t         pend_data;

    // One write in flight, strobes are dropped meanwhile.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pending <= 1'b0;
        end else if (pending) begin
            if (bus.gnt) pending <= 1'b0; // Write lands on this edge.
        end else if (i_cfg_we) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!pending && i_cfg_we) begin
            pend_addr <= {i_cfg_box, i_cfg_field};
            pend_data <= i_cfg_data;
        end
    end

    assign bus.req    = pending;
    assign bus.we     = 1'b1;
    assign bus.addr   = pend_addr;
    assign bus.wdata  = pend_data;
    assign o_cfg_busy = pending;

endmodule : box_host_port

// File: box_table/box_loader.sv
module box_loader #(
    parameter int N_BOX = 4,
    parameter int H_ACT = 64,
    parameter int V_ACT = 32
) (
    input  logic                                         clk,
    input  logic                                         i_reset,
    input  logic                                         i_vsync,
    box_bus_if.requester                                 bus,
    output logic [N_BOX*$bits(overlay_pkg::x_t)-1:0]     o_start_xs,
    output logic [N_BOX*$bits(overlay_pkg::y_t)-1:0]     o_start_ys,
    output logic [N_BOX*$bits(overlay_pkg::x_t)-1:0]     o_end_xs,
    output logic [N_BOX*$bits(overlay_pkg::y_t)-1:0]     o_end_ys,
    output logic [N_BOX*$bits(overlay_pkg::rgb_t)-1:0]   o_colors
);
    import overlay_pkg::*;

    localparam int BOX_W = box_w(N_BOX);

    typedef enum logic [1:0] {IDLE, READ, DONE} load_state_t;

    load_state_t      state;
    logic             vsync_d;
    logic [BOX_W-1:0] box_cnt;
    field_t           field_cnt;
    logic             rd_valid;
    logic [BOX_W-1:0] rd_box;
    field_t           rd_field;
    x_t               start_x [N_BOX];
    y_t               start_y [N_BOX];
    x_t               end_x   [N_BOX];
    y_t               end_y   [N_BOX];
    rgb_t             color   [N_BOX];

    function automatic x_t clamp_x(input box_data_t w);
        return (w >= box_data_t'(H_ACT)) ? x_t'(H_ACT - 1) : x_t'(w);
    endfunction

    function automatic y_t clamp_y(input box_data_t w);
        return (w >= box_data_t'(V_ACT)) ? y_t'(V_ACT - 1) : y_t'(w);
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state     <= IDLE;
            vsync_d   <= 1'b0;
            box_cnt   <= '0;
            field_cnt <= '0;
            rd_valid  <= 1'b0;
        end else begin
            vsync_d  <= i_vsync;
            rd_valid <= bus.req && bus.gnt;
            case (state)
                IDLE: if (i_vsync && !vsync_d) begin
                    state     <= READ;
                    box_cnt   <= '0;
                    field_cnt <= '0;
                end
                READ: if (bus.gnt) begin
                    if (field_cnt == field_t'(N_FIELD - 1)) begin
                        field_cnt <= '0;
                        if (box_cnt == BOX_W'(N_BOX - 1)) state <= DONE;
                        else box_cnt <= box_cnt + 1'b1;
                    end else begin
                        field_cnt <= field_cnt + 1'b1;
                    end
                end
                DONE: state <= IDLE; // Last word is captured here.
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_box   <= box_cnt;
        rd_field <= field_cnt;
    end

    // Shadows change only during the copy.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int k = 0; k < N_BOX; k++) begin
                start_x[k] <= '0;
                start_y[k] <= '0;
                end_x[k]   <= '0;
                end_y[k]   <= '0;
                color[k]   <= '0;
            end
        end else if (rd_valid) begin
            case (rd_field)
                FIELD_START_X: start_x[rd_box] <= clamp_x(bus.rdata);
                FIELD_START_Y: start_y[rd_box] <= clamp_y(bus.rdata);
                FIELD_END_X:   end_x[rd_box]   <= clamp_x(bus.rdata);
                FIELD_END_Y:   end_y[rd_box]   <= clamp_y(bus.rdata);
                FIELD_COLOR:   color[rd_box]   <= rgb_t'(bus.rdata);
                default: ;
            endcase
        end
    end

    always_comb begin
        for (int k = 0; k < N_BOX; k++) begin
            o_start_xs[k*$bits(x_t) +: $bits(x_t)]   = start_x[k];
            o_start_ys[k*$bits(y_t) +: $bits(y_t)]   = start_y[k];
            o_end_xs[k*$bits(x_t) +: $bits(x_t)]     = end_x[k];
            o_end_ys[k*$bits(y_t) +: $bits(y_t)]     = end_y[k];
            o_colors[k*$bits(rgb_t) +: $bits(rgb_t)] = color[k];
        end
    end

    assign bus.req   = (state == READ);
    assign bus.we    = 1'b0;
    assign bus.addr  = {box_cnt, field_cnt};
    assign bus.wdata = '0;

endmodule : box_loader

// File: box_table/box_table.sv
module box_table #(
    parameter int N_BOX = 4
) (
    input logic    clk,
    input logic    i_reset,
    box_bus_if.tbl loader_bus,
    box_bus_if.tbl host_bus
);
    import overlay_pkg::*;

    localparam int BOX_W  = box_w(N_BOX);
    localparam int ADDR_W = BOX_W + $bits(field_t);
    localparam int DEPTH  = N_FIELD * N_BOX;

    box_data_t         mem [DEPTH];
    logic              sel_loader;
    logic              sel_host;
    logic              acc_we;
    logic [ADDR_W-1:0] acc_addr;
    box_data_t         acc_wdata;
    logic [BOX_W-1:0]  acc_box;
    field_t            acc_field;
    logic              acc_ok;
    int unsigned       acc_idx;
    box_data_t         rd_data;

    // Fixed priority, loader first.
    assign sel_loader = loader_bus.req;
    assign sel_host   = host_bus.req && !loader_bus.req;

    assign loader_bus.gnt = sel_loader;
    assign host_bus.gnt   = sel_host;

    always_comb begin
        acc_we    = sel_loader ? loader_bus.we    : host_bus.we;
        acc_addr  = sel_loader ? loader_bus.addr  : host_bus.addr;
        acc_wdata = sel_loader ? loader_bus.wdata : host_bus.wdata;
    end

    assign {acc_box, acc_field} = acc_addr;
    assign acc_ok  = (acc_field < N_FIELD) && (acc_box < N_BOX); // Unused codes fall away.
    assign acc_idx = int'(acc_box) * N_FIELD + int'(acc_field);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int k = 0; k < DEPTH; k++) begin
                mem[k] <= '0; // Empty table, every box invalid.
            end
        end else if ((sel_loader || sel_host) && acc_we && acc_ok) begin
            mem[acc_idx] <= acc_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if ((sel_loader || sel_host) && !acc_we) begin
            rd_data <= acc_ok ? mem[acc_idx] : '0;
        end
    end

    assign loader_bus.rdata = rd_data;
    assign host_bus.rdata   = rd_data;

endmodule : box_table

// File: common/box_bus_if.sv
interface box_bus_if #(
    parameter int N_BOX = 4
);
    import overlay_pkg::*;

    localparam int ADDR_W = box_w(N_BOX) + $bits(field_t); // {box, field}.

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    box_data_t         wdata;
    logic              gnt;
    box_data_t         rdata; // Valid the cycle after a read grant.

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport tbl (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface : box_bus_if

// File: common/overlay_pkg.sv
package overlay_pkg;

    typedef logic [6:0]  x_t;        // Up to 128 columns.
    typedef logic [5:0]  y_t;        // Up to 64 lines.
    typedef logic [23:0] rgb_t;      // Red in the high byte.
    typedef logic [23:0] box_data_t; // Coordinates sit right-aligned.
    typedef logic [2:0]  field_t;

    // Field codes, low part of the table address.
    localparam field_t FIELD_START_X = 3'd0;
    localparam field_t FIELD_START_Y = 3'd1;
    localparam field_t FIELD_END_X   = 3'd2;
    localparam field_t FIELD_END_Y   = 3'd3;
    localparam field_t FIELD_COLOR   = 3'd4;

    localparam int N_FIELD = 5; // Words per box.

    // Width of a box index, never zero.
    function automatic int box_w(input int n_box);
        return (n_box > 1) ? $clog2(n_box) : 1;
    endfunction

endpackage : overlay_pkg

// File: design/box_overlay_top.sv
module box_overlay_top #(
    parameter int N_BOX       = 4,
    parameter int H_ACT       = 64,
    parameter int H_TOTAL     = 80,
    parameter int H_SYNC      = 8,
    parameter int V_ACT       = 32,
    parameter int V_TOTAL     = 40,
    parameter int V_SYNC      = 3,
    parameter int H_BOX_WIDTH = 1,
    parameter int V_BOX_WIDTH = 1
) (
    input  logic                                 clk,
    input  logic                                 i_reset,
    input  logic                                 i_cfg_we,
    input  logic [overlay_pkg::box_w(N_BOX)-1:0] i_cfg_box,
    input  overlay_pkg::field_t                  i_cfg_field,
    input  overlay_pkg::box_data_t               i_cfg_data,
    output logic                                 o_cfg_busy,
    input  logic [7:0]                           i_r,
    input  logic [7:0]                           i_g,
    input  logic [7:0]                           i_b,
    output overlay_pkg::x_t                      o_x,
    output overlay_pkg::y_t                      o_y,
    output logic                                 o_hsync,
    output logic                                 o_vsync,
    output logic                                 o_de,
    output logic [7:0]                           o_r,
    output logic [7:0]                           o_g,
    output logic [7:0]                           o_b
);
    import overlay_pkg::*;

    logic [N_BOX*$bits(x_t)-1:0]   start_xs;
    logic [N_BOX*$bits(y_t)-1:0]   start_ys;
    logic [N_BOX*$bits(x_t)-1:0]   end_xs;
    logic [N_BOX*$bits(y_t)-1:0]   end_ys;
    logic [N_BOX*$bits(rgb_t)-1:0] colors;

    box_bus_if #(.N_BOX(N_BOX)) loader_bus ();
    box_bus_if #(.N_BOX(N_BOX)) host_bus ();

    video_timing #(
        .H_ACT(H_ACT), .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC),
        .V_ACT(V_ACT), .V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC)
    ) video_timing_i (
        .clk(clk), .i_reset(i_reset), .o_x(o_x), .o_y(o_y),
        .o_hsync(o_hsync), .o_vsync(o_vsync), .o_de(o_de)
    );

    box_host_port #(.N_BOX(N_BOX)) box_host_port_i (
        .clk(clk), .i_reset(i_reset), .i_cfg_we(i_cfg_we), .i_cfg_box(i_cfg_box),
        .i_cfg_field(i_cfg_field), .i_cfg_data(i_cfg_data), .o_cfg_busy(o_cfg_busy),
        .bus(host_bus)
    );

    box_loader #(.N_BOX(N_BOX), .H_ACT(H_ACT), .V_ACT(V_ACT)) box_loader_i (
        .clk(clk), .i_reset(i_reset), .i_vsync(o_vsync), .bus(loader_bus),
        .o_start_xs(start_xs), .o_start_ys(start_ys),
        .o_end_xs(end_xs), .o_end_ys(end_ys), .o_colors(colors)
    );

    box_table #(.N_BOX(N_BOX)) box_table_i (
        .clk(clk), .i_reset(i_reset), .loader_bus(loader_bus), .host_bus(host_bus)
    );

    draw_window #(
        .N_BOX(N_BOX), .H_ACT(H_ACT), .V_ACT(V_ACT),
        .H_BOX_WIDTH(H_BOX_WIDTH), .V_BOX_WIDTH(V_BOX_WIDTH)
    ) draw_window_i (
        .i_x(o_x), .i_y(o_y), .i_start_xs(start_xs), .i_start_ys(start_ys),
        .i_end_xs(end_xs), .i_end_ys(end_ys), .i_colors(colors),
        .i_r(i_r), .i_g(i_g), .i_b(i_b), .o_r(o_r), .o_g(o_g), .o_b(o_b)
    );

endmodule : box_overlay_top

// File: design/draw_window.sv
module draw_window #(
    parameter int N_BOX       = 4,
    parameter int H_ACT       = 64,
    parameter int V_ACT       = 32,
    parameter int H_BOX_WIDTH = 1,
    parameter int V_BOX_WIDTH = 1
) (
    input  overlay_pkg::x_t                            i_x,
    input  overlay_pkg::y_t                            i_y,
    input  logic [N_BOX*$bits(overlay_pkg::x_t)-1:0]   i_start_xs,
    input  logic [N_BOX*$bits(overlay_pkg::y_t)-1:0]   i_start_ys,
    input  logic [N_BOX*$bits(overlay_pkg::x_t)-1:0]   i_end_xs,
    input  logic [N_BOX*$bits(overlay_pkg::y_t)-1:0]   i_end_ys,
    input  logic [N_BOX*$bits(overlay_pkg::rgb_t)-1:0] i_colors,
    input  logic [7:0]                                 i_r,
    input  logic [7:0]                                 i_g,
    input  logic [7:0]                                 i_b,
    output logic [7:0]                                 o_r,
    output logic [7:0]                                 o_g,
    output logic [7:0]                                 o_b
);
    import overlay_pkg::*;

    localparam int X_W = $bits(x_t);
    localparam int Y_W = $bits(y_t);
    localparam int C_W = $bits(rgb_t);

    logic [N_BOX-1:0] hit;
    rgb_t             box_rgb [N_BOX];
    logic             in_area;
    rgb_t             pix;

    for (genvar i = 0; i < N_BOX; i++) begin : g_box
        x_t   sx, ex;
        y_t   sy, ey;
        int   ex_out, sx_in, sy_out, ey_in;
        logic outer, inner, valid;

        assign sx = i_start_xs[i*X_W +: X_W];
        assign sy = i_start_ys[i*Y_W +: Y_W];
        assign ex = i_end_xs[i*X_W +: X_W];
        assign ey = i_end_ys[i*Y_W +: Y_W];

        // Border grows right and up, and may reach past the screen edge.
        assign ex_out = int'(ex) + H_BOX_WIDTH;
        assign sx_in  = int'(sx) + H_BOX_WIDTH;
        assign sy_out = int'(sy) - V_BOX_WIDTH;
        assign ey_in  = int'(ey) - V_BOX_WIDTH;

        assign outer = (i_x >= sx) && (int'(i_x) <= ex_out)
                       && (int'(i_y) >= sy_out) && (i_y <= ey);
        assign inner = (int'(i_x) >= sx_in) && (i_x <= ex)
                       && (i_y >= sy) && (int'(i_y) <= ey_in);

        assign valid = ((sx != '0) && (sy != '0)) || ((ex != '0) && (ey != '0));

        assign hit[i]     = valid && outer && !inner;
        assign box_rgb[i] = i_colors[i*C_W +: C_W];
    end

    assign in_area = (i_x < X_W'(H_ACT)) && (i_y < Y_W'(V_ACT));

    // Later boxes overwrite earlier ones.
    always_comb begin
        pix = {i_r, i_g, i_b};
        for (int j = 0; j < N_BOX; j++) begin
            if (in_area && hit[j]) pix = box_rgb[j];
        end
    end

    assign {o_r, o_g, o_b} = pix;

endmodule : draw_window

// File: design/video_timing.sv
module video_timing #(
    parameter int H_ACT   = 64,
    parameter int H_TOTAL = 80,
    parameter int H_SYNC  = 8,
    parameter int V_ACT   = 32,
    parameter int V_TOTAL = 40,
    parameter int V_SYNC  = 3
) (
    input  logic            clk,
    input  logic            i_reset,
    output overlay_pkg::x_t o_x,
    output overlay_pkg::y_t o_y,
    output logic            o_hsync,
    output logic            o_vsync,
    output logic            o_de
);
    import overlay_pkg::*;

    localparam int H_W = $clog2(H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_last;

    assign h_last = (h_cnt == H_W'(H_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_cnt == V_W'(V_TOTAL - 1)) v_cnt <= '0;
            else v_cnt <= v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Coordinates and levels leave on the same edge.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_x     <= '0;
            o_y     <= '0;
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
        end else begin
            o_x     <= x_t'(h_cnt);
            o_y     <= y_t'(v_cnt);
            o_hsync <= (h_cnt >= H_W'(H_TOTAL - H_SYNC)); // Last columns.
            o_vsync <= (v_cnt >= V_W'(V_TOTAL - V_SYNC)); // Last lines.
            o_de    <= (h_cnt < H_W'(H_ACT)) && (v_cnt < V_W'(V_ACT));
        end
    end

endmodule : video_timing

// File: flist.f
common/overlay_pkg.sv
common/box_bus_if.sv
box_table/box_table.sv
box_table/box_host_port.sv
box_table/box_loader.sv
design/video_timing.sv
design/draw_window.sv
design/box_overlay_top.sv
tests/overlay_checker.sv
tests/tb_box_overlay.sv

// File: run_sim.sh
#!/bin/sh
# Builds the box overlay testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_box_overlay \
    -f flist.f \
    -o sim_box_overlay

./obj_dir/sim_box_overlay > sim.log 2>&1
cat sim.log

if grep -qx 'TEST RESULT: PASS' sim.log; then
    exit 0
fi
exit 1

// File: tests/overlay_checker.sv
module overlay_checker #(
    parameter int N_BOX       = 4,
    parameter int H_ACT       = 64,
    parameter int H_TOTAL     = 80,
    parameter int H_SYNC      = 8,
    parameter int V_ACT       = 32,
    parameter int V_TOTAL     = 40,
    parameter int V_SYNC      = 3,
    parameter int H_BOX_WIDTH = 1,
    parameter int V_BOX_WIDTH = 1
) (
    input  logic                                 clk,
    input  logic                                 i_reset,
    input  logic                                 i_cfg_we,
    input  logic [overlay_pkg::box_w(N_BOX)-1:0] i_cfg_box,
    input  overlay_pkg::field_t                  i_cfg_field,
    input  overlay_pkg::box_data_t               i_cfg_data,
    input  logic                                 i_cfg_busy,
    input  logic                                 i_hsync,
    input  logic                                 i_vsync,
    input  logic                                 i_de,
    input  overlay_pkg::x_t                      i_x,
    input  overlay_pkg::y_t                      i_y,
    input  overlay_pkg::rgb_t                    i_bg,
    input  logic [7:0]                           i_pix_r,
    input  logic [7:0]                           i_pix_g,
    input  logic [7:0]                           i_pix_b,
    input  logic                                 i_report,
    output int                                   o_frames,
    output int                                   o_checks,
    output int                                   o_errors,
    output logic                                 o_done
);
    import overlay_pkg::*;

    localparam int BUSY_MAX = N_FIELD * N_BOX + 4; // Longest loader copy plus slack.

    box_data_t tbl [N_BOX][N_FIELD]; // What the host has written.
    box_data_t shd [N_BOX][N_FIELD]; // What the picture shows.
    int        checks [6];
    int        errs   [6];
    int        pix_checks;
    int        pix_errs;
    int        n_accept;
    int        n_drop;
    int        busy_run;
    int        uncovered;
    logic      vsync_q;
    logic      accepted_q;
    int        h_m;
    int        v_m;
    logic      tm_first;
    int        tm_checks;
    int        tm_errs;

    // Outline rule on the shadow boxes.
    function automatic rgb_t expect_pixel(input int x, input int y, input rgb_t bg,
                                          output int n_hit, output int n_valid,
                                          output logic inv_hit);
        rgb_t pix;
        int   sx;
        int   ex;
        int   sy;
        int   ey;
        logic valid;
        logic outer;
        logic inner;
        pix     = bg;
        n_hit   = 0;
        n_valid = 0;
        inv_hit = 1'b0;
        for (int k = 0; k < N_BOX; k++) begin
            sx    = int'(shd[k][FIELD_START_X]);
            sy    = int'(shd[k][FIELD_START_Y]);
            ex    = int'(shd[k][FIELD_END_X]);
            ey    = int'(shd[k][FIELD_END_Y]);
            valid = ((sx != 0) && (sy != 0)) || ((ex != 0) && (ey != 0));
            outer = (x >= sx) && (x <= ex + H_BOX_WIDTH)
                    && (y >= sy - V_BOX_WIDTH) && (y <= ey);
            inner = (x >= sx + H_BOX_WIDTH) && (x <= ex)
                    && (y >= sy) && (y <= ey - V_BOX_WIDTH);
            if (valid) n_valid++;
            if (outer && !inner) begin
                if (valid) begin
                    pix = rgb_t'(shd[k][FIELD_COLOR]); // Higher index overwrites.
                    n_hit++;
                end else begin
                    inv_hit = 1'b1;
                end
            end
        end
        return pix;
    endfunction

    function automatic logic shadow_empty();
        logic e;
        e = 1'b1;
        for (int k = 0; k < N_BOX; k++) begin
            for (int f = 0; f < N_FIELD; f++) begin
                if (shd[k][f] != '0) e = 1'b0;
            end
        end
        return e;
    endfunction

    function automatic logic edits_pending();
        logic d;
        d = 1'b0;
        for (int k = 0; k < N_BOX; k++) begin
            for (int f = 0; f < N_FIELD; f++) begin
                if (tbl[k][f] != shd[k][f]) d = 1'b1;
            end
        end
        return d;
    endfunction

    task automatic check_channel(input string name, input logic [7:0] exp_v,
                                 input logic [7:0] act_v, inout logic bad);
        if (act_v !== exp_v) begin
            $display("[ERROR] t=%0t %s: expected %02h, actual %02h (x=%0d, y=%0d)",
                     $time, name, exp_v, act_v, i_x, i_y);
            bad = 1'b1;
        end
    endtask

    task automatic check_timing(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        tm_checks++;
        if (act_v !== exp_v) begin
            $display("[ERROR] t=%0t %s: expected %0d, actual %0d",
                     $time, name, exp_v, act_v);
            tm_errs++;
        end
    endtask

    task automatic tally(input int idx, input logic hit, input logic bad);
        if (hit) begin
            checks[idx]++;
            if (bad) errs[idx]++;
        end
    endtask

    task automatic report_line(input int idx, input string what, input logic covered);
        if (!covered) begin
            $display("Behaviour %0d, %s: never exercised by the stimulus", idx + 1, what);
            uncovered++;
        end else if (errs[idx] != 0) begin
            $display("Behaviour %0d, %s: %0d checks, %0d errors, failed",
                     idx + 1, what, checks[idx], errs[idx]);
        end else begin
            $display("Behaviour %0d, %s: %0d checks, passed", idx + 1, what, checks[idx]);
        end
    endtask

    always @(posedge clk) begin
        rgb_t exp_pix;
        int   n_hit;
        int   n_valid;
        logic inv_hit;
        logic bad;
        if (i_reset) begin
            for (int k = 0; k < N_BOX; k++) begin
                for (int f = 0; f < N_FIELD; f++) begin
                    tbl[k][f] = '0;
                    shd[k][f] = '0;
                end
            end
            for (int i = 0; i < 6; i++) begin
                checks[i] = 0;
                errs[i]   = 0;
            end
            pix_checks = 0;
            pix_errs   = 0;
            n_accept   = 0;
            n_drop     = 0;
            busy_run   = 0;
            uncovered  = 0;
            vsync_q    = 1'b0;
            accepted_q = 1'b0;
            h_m        = 0;
            v_m        = 0;
            tm_first   = 1'b1;
            tm_checks  = 0;
            tm_errs    = 0;
            o_frames   = 0;
            o_checks   = 0;
            o_errors   = 0;
            o_done     = 1'b0;
        end else begin
            // First cycle out of reset still shows the reset levels.
            check_timing("o_x", h_m, i_x);
            check_timing("o_y", v_m, i_y);
            check_timing("o_hsync", !tm_first && (h_m >= H_TOTAL - H_SYNC), i_hsync);
            check_timing("o_vsync", !tm_first && (v_m >= V_TOTAL - V_SYNC), i_vsync);
            check_timing("o_de", !tm_first && (h_m < H_ACT) && (v_m < V_ACT), i_de);
            if (!tm_first) begin
                h_m = (h_m == H_TOTAL - 1) ? 0 : h_m + 1;
                if (h_m == 0) v_m = (v_m == V_TOTAL - 1) ? 0 : v_m + 1;
            end
            tm_first = 1'b0;

            if (i_de) begin
                exp_pix = expect_pixel(i_x, i_y, i_bg, n_hit, n_valid, inv_hit);
                bad     = 1'b0;
                check_channel("o_r", exp_pix[23:16], i_pix_r, bad);
                check_channel("o_g", exp_pix[15:8], i_pix_g, bad);
                check_channel("o_b", exp_pix[7:0], i_pix_b, bad);
                pix_checks++;
                if (bad) pix_errs++;
                tally(0, shadow_empty(), bad);
                tally(1, (n_valid > 0) && (n_hit <= 1), bad);
                tally(2, n_hit >= 2, bad);
                tally(3, inv_hit, bad);
                tally(4, edits_pending(), bad);
            end

            if (accepted_q && !i_cfg_busy) begin
                $display("t=%0t: o_cfg_busy did not rise after an accepted write", $time);
                errs[5]++;
            end
            busy_run = i_cfg_busy ? busy_run + 1 : 0;
            if (busy_run == BUSY_MAX) begin
                $display("t=%0t: o_cfg_busy stayed high for %0d cycles", $time, BUSY_MAX);
                errs[5]++;
            end
            accepted_q = i_cfg_we && !i_cfg_busy;
            if (i_cfg_we) begin
                checks[5]++;
                if (i_cfg_busy) begin
                    n_drop++; // Dropped, the table keeps its word.
                end else begin
                    n_accept++;
                    if (i_cfg_field < N_FIELD && i_cfg_box < N_BOX)
                        tbl[i_cfg_box][i_cfg_field] = i_cfg_data;
                end
            end

            if (i_vsync && !vsync_q) begin
                for (int k = 0; k < N_BOX; k++) begin
                    for (int f = 0; f < N_FIELD; f++) begin
                        shd[k][f] = tbl[k][f];
                    end
                end
                o_frames++;
            end
            vsync_q = i_vsync;

            if (i_report && !o_done) begin
                report_line(0, "empty table passes input", checks[0] > 0);
                report_line(1, "single box outline", checks[1] > 0);
                report_line(2, "overlap priority", checks[2] > 0);
                report_line(3, "invalid box not drawn", checks[3] > 0);
                report_line(4, "edits wait for vsync", checks[4] > 0);
                report_line(5, "busy and dropped strobes", (n_accept > 0) && (n_drop > 0));
                $display("Video timing: %0d checks, %0d errors", tm_checks, tm_errs);
                o_checks = pix_checks + checks[5] + tm_checks;
                o_errors = pix_errs + errs[5] + uncovered + tm_errs;
                o_done   = 1'b1;
            end
        end
    end

endmodule : overlay_checker

// File: tests/tb_box_overlay.sv
module tb_box_overlay;
    import overlay_pkg::*;

    localparam int N_BOX    = 4;
    localparam int H_ACT    = 64;
    localparam int H_TOTAL  = 80;
    localparam int H_SYNC   = 8;
    localparam int V_ACT    = 32;
    localparam int V_TOTAL  = 40;
    localparam int V_SYNC   = 3;
    localparam int BOX_W    = box_w(N_BOX);
    localparam int N_FRAMES = 6;
    localparam int LIMIT    = N_FRAMES * H_TOTAL * V_TOTAL + 200;

    logic             clk;
    logic             i_reset;
    logic             i_cfg_we;
    logic [BOX_W-1:0] i_cfg_box;
    field_t           i_cfg_field;
    box_data_t        i_cfg_data;
    logic             o_cfg_busy;
    logic [7:0]       i_r;
    logic [7:0]       i_g;
    logic [7:0]       i_b;
    x_t               o_x;
    y_t               o_y;
    logic             o_hsync;
    logic             o_vsync;
    logic             o_de;
    logic [7:0]       o_r;
    logic [7:0]       o_g;
    logic [7:0]       o_b;
    int               seed;
    int               cycles = 0;
    int               setup_step;
    logic             report;
    int               frames;
    int               checks;
    int               errors;
    logic             report_done;

    box_overlay_top #(
        .N_BOX(N_BOX), .H_ACT(H_ACT), .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC),
        .V_ACT(V_ACT), .V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .H_BOX_WIDTH(1), .V_BOX_WIDTH(1)
    ) box_overlay_top_i (
        .clk(clk), .i_reset(i_reset), .i_cfg_we(i_cfg_we), .i_cfg_box(i_cfg_box),
        .i_cfg_field(i_cfg_field), .i_cfg_data(i_cfg_data), .o_cfg_busy(o_cfg_busy),
        .i_r(i_r), .i_g(i_g), .i_b(i_b), .o_x(o_x), .o_y(o_y), .o_hsync(o_hsync),
        .o_vsync(o_vsync), .o_de(o_de), .o_r(o_r), .o_g(o_g), .o_b(o_b)
    );

    overlay_checker #(
        .N_BOX(N_BOX), .H_ACT(H_ACT), .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC),
        .V_ACT(V_ACT), .V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .H_BOX_WIDTH(1), .V_BOX_WIDTH(1)
    ) overlay_checker_i (
        .clk(clk), .i_reset(i_reset), .i_cfg_we(i_cfg_we), .i_cfg_box(i_cfg_box),
        .i_cfg_field(i_cfg_field), .i_cfg_data(i_cfg_data), .i_cfg_busy(o_cfg_busy),
        .i_hsync(o_hsync), .i_vsync(o_vsync), .i_de(o_de), .i_x(o_x), .i_y(o_y),
        .i_bg({i_r, i_g, i_b}), .i_pix_r(o_r), .i_pix_g(o_g), .i_pix_b(o_b),
        .i_report(report), .o_frames(frames), .o_checks(checks), .o_errors(errors),
        .o_done(report_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Box 0 gets zero x on both corners, so it stays invalid.
    task automatic setup_write();
        i_cfg_we  = 1'b1;
        i_cfg_box = '0;
        case (setup_step)
            0: begin
                i_cfg_field = FIELD_START_Y;
                i_cfg_data  = box_data_t'(4);
            end
            1: begin
                i_cfg_field = FIELD_END_Y;
                i_cfg_data  = box_data_t'(V_ACT - 8);
            end
            default: begin
                i_cfg_field = FIELD_COLOR;
                i_cfg_data  = 24'hff00ff;
            end
        endcase
        setup_step++;
    endtask

    // Starts in the low half and ends in the high half, so boxes cross.
    task automatic random_write();
        int unsigned f;
        int unsigned v;
        logic [31:0] z;
        f = $unsigned($random(seed)) % N_FIELD;
        v = $unsigned($random(seed));
        z = $random(seed);
        i_cfg_we    = 1'b1;
        i_cfg_box   = BOX_W'(1 + z[27:24] % (N_BOX - 1));
        i_cfg_field = field_t'(f);
        case (field_t'(f))
            FIELD_START_X: i_cfg_data = box_data_t'(1 + v % (H_ACT / 2 - 1));
            FIELD_END_X:   i_cfg_data = box_data_t'(H_ACT / 2 + v % (H_ACT / 2));
            FIELD_START_Y: i_cfg_data = box_data_t'(1 + v % (V_ACT / 2 - 1));
            FIELD_END_Y:   i_cfg_data = box_data_t'(V_ACT / 2 + v % (V_ACT / 2));
            default:       i_cfg_data = z[23:0];
        endcase
        if (f < N_FIELD - 1 && z[31:28] == 4'd0) i_cfg_data = '0; // Some corners stay zero.
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        logic [31:0] pick;
        r    = $random(seed);
        pick = $random(seed);
        {i_r, i_g, i_b} = r[23:0];
        if (i_cfg_we && o_cfg_busy && pick[1:0] == 2'd0) begin
            i_cfg_data = box_data_t'($random(seed)); // Second strobe while busy.
        end else if (!o_vsync && !o_cfg_busy && setup_step < 3) begin
            setup_write();
        end else if (!o_vsync && !o_cfg_busy && pick[6:2] == 5'd0) begin
            random_write();
        end else begin
            i_cfg_we = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        seed        = 32'h2e30_2b93;
        setup_step  = 0;
        report      = 1'b0;
        i_reset     = 1'b1;
        i_cfg_we    = 1'b0;
        i_cfg_box   = '0;
        i_cfg_field = '0;
        i_cfg_data  = '0;
        i_r         = '0;
        i_g         = '0;
        i_b         = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        while (frames < N_FRAMES) begin
            @(negedge clk);
            drive_cycle();
        end
        i_cfg_we = 1'b0;
        report   = 1'b1;
        while (!report_done) @(negedge clk);
        $display("Summary: %0d frames, %0d checks, %0d errors", frames, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_box_overlay
